// ==== flist.f ====
hdl/relay_pkg.sv
hdl/ctrl_if.sv
hdl/instr_decoder.sv
hdl/sequencer_fsm.sv
hdl/control_matrix.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/relay_cpu_top.sv
tests/relay_cpu_chk.sv
tests/relay_cpu_tb.sv

// ==== hdl/alu_unit.sv ====
// combinational eight-function ALU working on the B and C registers
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
	input  relay_pkg::data_t b,
	input  relay_pkg::data_t c,
	ctrl_if.sink             ctrl,
	output relay_pkg::data_t result
);
	import relay_pkg::*;

	// all arithmetic wraps at eight bits, the single-operand functions use B only
	always_comb
	begin
		case (ctrl.alu_func)
			alu_add: result = b + c;
			alu_inc: result = b + 8'd1;
			alu_and: result = b & c;
			alu_or:  result = b | c;
			alu_xor: result = b ^ c;
			alu_not: result = ~b;
			// bit 7 drops out, a zero enters at bit 0
			alu_shl: result = {b[6:0], 1'b0};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/control_matrix.sv ====
// control matrix that turns the sequencer step and instruction into strobes and bus requests
`timescale 1ns/1ns
`default_nettype none

module control_matrix (
	input  relay_pkg::seq_state_t   state,
	input  relay_pkg::instr_word_t  instr,
	input  relay_pkg::instr_class_t class_code,
	input  logic                    is_mov16,
	input  logic                    ack,
	output logic                    cyc,
	output logic                    stb,
	output logic                    we,
	output logic                    mem_addr_sel,
	output logic                    hold,
	ctrl_if.source                  ctrl
);
	import relay_pkg::*;

	// the ALU function field is always presented, only step 6 of an ALU op uses it
	assign ctrl.alu_func = instr.arith.func;

	// a memory step keeps the sequencer in place until the slave acknowledges
	assign hold = cyc && !ack;

	always_comb
	begin
		cyc             = 1'b0;
		stb             = 1'b0;
		we              = 1'b0;
		mem_addr_sel    = 1'b0;
		ctrl.reg_load   = 1'b0;
		ctrl.reg_dst    = sel_a;
		ctrl.bus_src    = src_reg;
		ctrl.ir_load    = 1'b0;
		ctrl.pc_inc     = 1'b0;
		ctrl.pc_from_j  = 1'b0;
		ctrl.j1_load    = 1'b0;
		ctrl.j2_load    = 1'b0;
		ctrl.xy_inc     = 1'b0;
		ctrl.xy_from_m  = 1'b0;
		case (state)
			state_2:
			begin
				// opcode fetch at the PC, the byte is taken on the acknowledging edge
				cyc          = 1'b1;
				stb          = 1'b1;
				ctrl.ir_load = ack;
			end
			state_3: ctrl.pc_inc = 1'b1;
			state_6:
			begin
				case (class_code)
					mov_8:
					begin
						ctrl.reg_load = 1'b1;
						ctrl.reg_dst  = instr.mov.dst;
						ctrl.bus_src  = src_reg;
					end
					alu:
					begin
						ctrl.reg_load = 1'b1;
						ctrl.reg_dst  = instr.arith.dest ? sel_d : sel_a;
						ctrl.bus_src  = src_alu;
					end
					setab:
					begin
						ctrl.reg_load = 1'b1;
						ctrl.reg_dst  = instr.imm.dest ? sel_b : sel_a;
						ctrl.bus_src  = src_imm;
					end
					mov16_halt: ctrl.xy_from_m = is_mov16;
					default: ctrl.reg_load = 1'b0;
				endcase
			end
			state_10:
			begin
				if (class_code == load_store)
				begin
					// data access at M1:M2, a load writes A to D from the read data
					cyc           = 1'b1;
					stb           = 1'b1;
					we            = instr.ldst.store;
					mem_addr_sel  = 1'b1;
					ctrl.reg_load = !instr.ldst.store && ack;
					ctrl.reg_dst  = reg_sel_t'({1'b0, instr.ldst.rsel});
					ctrl.bus_src  = src_mem;
				end
				else if (class_code == goto)
				begin
					// high jump byte follows the opcode
					cyc          = 1'b1;
					stb          = 1'b1;
					ctrl.j1_load = ack;
				end
			end
			state_11: ctrl.pc_inc = (class_code == goto);
			state_13: ctrl.xy_inc = (class_code == inc_xy);
			state_18:
			begin
				cyc          = (class_code == goto);
				stb          = (class_code == goto);
				ctrl.j2_load = (class_code == goto) && ack;
			end
			state_19: ctrl.pc_inc = (class_code == goto);
			state_23: ctrl.pc_from_j = (class_code == goto);
			default: cyc = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/ctrl_if.sv ====
// control bundle carrying register, program counter and ALU strobes out of the control matrix
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;
	import relay_pkg::*;

	// write enable and target for the user register file
	logic      reg_load;
	reg_sel_t  reg_dst;
	bus_src_t  bus_src;
	logic      ir_load;
	// program counter controls
	logic      pc_inc;
	logic      pc_from_j;
	// jump register loads during goto
	logic      j1_load;
	logic      j2_load;
	// 16-bit X:Y operations
	logic      xy_inc;
	logic      xy_from_m;
	alu_func_t alu_func;

	modport source (
		output reg_load, reg_dst, bus_src, ir_load, pc_inc, pc_from_j,
		output j1_load, j2_load, xy_inc, xy_from_m, alu_func
	);

	modport sink (
		input reg_load, reg_dst, bus_src, ir_load, pc_inc, pc_from_j,
		input j1_load, j2_load, xy_inc, xy_from_m, alu_func
	);

endinterface

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// instruction decoder that sorts the instruction register into a class and picks out sub-codes
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  relay_pkg::instr_word_t  instr,
	output relay_pkg::instr_class_t class_code,
	output logic                    is_halt,
	output logic                    is_mov16
);
	import relay_pkg::*;

	// two-bit tags are tested first, the rest of the space is split on the four-bit tag
	always_comb
	begin
		if (instr.mov.tag == 2'b00)
			class_code = mov_8;
		else if (instr.imm.tag == 2'b01)
			class_code = setab;
		else
		begin
			case (instr.arith.tag)
				4'b1000: class_code = alu;
				4'b1001: class_code = load_store;
				// only the plain 1011_0000 byte increments X:Y
				4'b1011: class_code = (instr.raw == 8'b1011_0000) ? inc_xy : mov16_halt;
				4'b1100, 4'b1101, 4'b1110, 4'b1111: class_code = goto;
				// 1010 and unused encodings run as a 12-step no-op
				default: class_code = mov16_halt;
			endcase
		end
	end

	// sub-codes only count inside the mov16/halt class
	assign is_halt  = (class_code == mov16_halt) && (instr.raw == halt_opcode);
	assign is_mov16 = (class_code == mov16_halt) && (instr.raw == mov16_opcode);

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
// register file with user registers, instruction register, PC and jump registers on one data bus
`timescale 1ns/1ns
`default_nettype none

module register_file #(
	parameter relay_pkg::addr_t reset_vector = '0
) (
	input  logic                   clock,
	input  logic                   rst,
	ctrl_if.sink                   ctrl,
	input  relay_pkg::data_t       alu_result,
	input  relay_pkg::data_t       mem_rdata,
	input  logic                   mem_addr_sel,
	output relay_pkg::instr_word_t instr,
	output relay_pkg::data_t       reg_b,
	output relay_pkg::data_t       reg_c,
	output relay_pkg::addr_t       adr,
	output relay_pkg::data_t       wdata
);
	import relay_pkg::*;

	data_t regs [8];
	data_t j1;
	data_t j2;
	addr_t pc;
	data_t bus;

	// internal data bus, setab immediates are sign extended from five bits
	always_comb
	begin
		case (ctrl.bus_src)
			src_reg: bus = regs[instr.mov.src];
			src_alu: bus = alu_result;
			src_imm: bus = data_t'(instr.imm.value);
			default: bus = mem_rdata;
		endcase
	end

	// instruction register and PC start from a known point
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			instr <= '0;
			pc    <= reset_vector;
		end
		else
		begin
			if (ctrl.ir_load)
				instr <= mem_rdata;
			if (ctrl.pc_from_j)
				pc <= {j1, j2};
			else if (ctrl.pc_inc)
				pc <= pc + 16'd1;
		end
	end

	// user and jump registers, the X:Y operations land after a bus write to the same pair
	always_ff @(posedge clock)
	begin
		if (ctrl.reg_load)
			regs[ctrl.reg_dst] <= bus;
		if (ctrl.xy_inc)
			{regs[sel_x], regs[sel_y]} <= {regs[sel_x], regs[sel_y]} + 16'd1;
		else if (ctrl.xy_from_m)
			{regs[sel_x], regs[sel_y]} <= {regs[sel_m1], regs[sel_m2]};
		if (ctrl.j1_load)
			j1 <= mem_rdata;
		if (ctrl.j2_load)
			j2 <= mem_rdata;
	end

	assign reg_b = regs[sel_b];
	assign reg_c = regs[sel_c];

	// data accesses use M1:M2, fetches and goto bytes come from the PC
	assign adr   = mem_addr_sel ? {regs[sel_m1], regs[sel_m2]} : pc;
	assign wdata = regs[reg_sel_t'({1'b0, instr.ldst.rsel})];

endmodule

`default_nettype wire

// ==== hdl/relay_cpu_top.sv ====
// relay computer core with a Wishbone classic master port toward external memory
`timescale 1ns/1ns
`default_nettype none

module relay_cpu_top #(
	parameter relay_pkg::addr_t reset_vector = '0
) (
	input  logic             clock,
	input  logic             rst,
	output relay_pkg::addr_t wb_adr,
	output relay_pkg::data_t wb_dat_o,
	input  relay_pkg::data_t wb_dat_i,
	output logic             wb_we,
	output logic             wb_cyc,
	output logic             wb_stb,
	input  logic             wb_ack,
	output logic             halted
);
	import relay_pkg::*;

	instr_word_t  instr;
	instr_class_t class_code;
	logic         is_halt;
	logic         is_mov16;
	seq_state_t   state;
	logic         hold;
	logic         mem_addr_sel;
	data_t        reg_b;
	data_t        reg_c;
	data_t        alu_result;

	ctrl_if ctrl ();

	instr_decoder u_decoder (
		.instr      (instr),
		.class_code (class_code),
		.is_halt    (is_halt),
		.is_mov16   (is_mov16)
	);

	sequencer_fsm u_sequencer (
		.clock      (clock),
		.rst        (rst),
		.class_code (class_code),
		.hold       (hold),
		.is_halt    (is_halt),
		.state      (state),
		.halted     (halted)
	);

	control_matrix u_control (
		.state        (state),
		.instr        (instr),
		.class_code   (class_code),
		.is_mov16     (is_mov16),
		.ack          (wb_ack),
		.cyc          (wb_cyc),
		.stb          (wb_stb),
		.we           (wb_we),
		.mem_addr_sel (mem_addr_sel),
		.hold         (hold),
		.ctrl         (ctrl.source)
	);

	register_file #(
		.reset_vector (reset_vector)
	) u_regs (
		.clock        (clock),
		.rst          (rst),
		.ctrl         (ctrl.sink),
		.alu_result   (alu_result),
		.mem_rdata    (wb_dat_i),
		.mem_addr_sel (mem_addr_sel),
		.instr        (instr),
		.reg_b        (reg_b),
		.reg_c        (reg_c),
		.adr          (wb_adr),
		.wdata        (wb_dat_o)
	);

	alu_unit u_alu (
		.b      (reg_b),
		.c      (reg_c),
		.ctrl   (ctrl.sink),
		.result (alu_result)
	);

endmodule

`default_nettype wire

// ==== hdl/relay_pkg.sv ====
// relay core shared types: data and address words, instruction classes, codes and states
`default_nettype none

package relay_pkg;

	typedef logic [7:0] data_t;
	typedef logic [15:0] addr_t;

	// instruction class codes, as the sequencer exit logic sees them
	typedef enum logic [3:0] {
		mov_8      = 4'b0000,
		alu        = 4'b1000,
		setab      = 4'b0100,
		inc_xy     = 4'b1011,
		load_store = 4'b1001,
		goto       = 4'b1100,
		mov16_halt = 4'b1010
	} instr_class_t;

	// user register codes in encoding order
	typedef enum logic [2:0] {
		sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y
	} reg_sel_t;

	typedef enum logic [2:0] {
		alu_add, alu_inc, alu_and, alu_or, alu_xor, alu_not, alu_shl, alu_clr
	} alu_func_t;

	// source that drives the internal data bus during a register write
	typedef enum logic [1:0] {
		src_reg, src_alu, src_imm, src_mem
	} bus_src_t;

	// one instruction byte seen through each of its field layouts
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] tag;
			reg_sel_t   dst;
			reg_sel_t   src;
		} mov;
		struct packed {
			logic [3:0] tag;
			// 0 writes A, 1 writes D
			logic       dest;
			alu_func_t  func;
		} arith;
		struct packed {
			logic [1:0]        tag;
			// 0 writes A, 1 writes B
			logic              dest;
			logic signed [4:0] value;
		} imm;
		struct packed {
			logic [3:0] tag;
			logic       store;
			logic       spare;
			logic [1:0] rsel;
		} ldst;
	} instr_word_t;

	// one-hot sequencer steps, the bit position is the step number minus one
	typedef enum logic [23:0] {
		state_1  = 24'h000001,
		state_2  = 24'h000002,
		state_3  = 24'h000004,
		state_4  = 24'h000008,
		state_5  = 24'h000010,
		state_6  = 24'h000020,
		state_7  = 24'h000040,
		state_8  = 24'h000080,
		state_9  = 24'h000100,
		state_10 = 24'h000200,
		state_11 = 24'h000400,
		state_12 = 24'h000800,
		state_13 = 24'h001000,
		state_14 = 24'h002000,
		state_15 = 24'h004000,
		state_16 = 24'h008000,
		state_17 = 24'h010000,
		state_18 = 24'h020000,
		state_19 = 24'h040000,
		state_20 = 24'h080000,
		state_21 = 24'h100000,
		state_22 = 24'h200000,
		state_23 = 24'h400000,
		state_24 = 24'h800000
	} seq_state_t;

	localparam data_t halt_opcode = 8'b1010_1110;
	// copies M1:M2 into X:Y
	localparam data_t mov16_opcode = 8'b1010_0000;

	// number of sequencer steps an instruction class runs for
	function automatic int unsigned step_count(input instr_class_t cls);
		case (cls)
			mov_8, alu, setab: return 8;
			load_store, mov16_halt: return 12;
			inc_xy: return 14;
			goto: return 24;
			default: return 12;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hdl/sequencer_fsm.sv ====
// one-hot 24-step sequencer with class-dependent return points, memory hold and halt
`timescale 1ns/1ns
`default_nettype none

module sequencer_fsm (
	input  logic                    clock,
	input  logic                    rst,
	input  relay_pkg::instr_class_t class_code,
	input  logic                    hold,
	input  logic                    is_halt,
	output relay_pkg::seq_state_t   state,
	output logic                    halted
);
	import relay_pkg::*;

	seq_state_t next_state;

	// the state register moves one step per clock unless a memory step is waiting
	always_ff @(posedge clock)
	begin
		if (rst)
			state <= state_1;
		else if (!hold)
			state <= next_state;
	end

	// halted stays up until reset once a halt instruction reaches step 12
	always_ff @(posedge clock)
	begin
		if (rst)
			halted <= 1'b0;
		else if (state == state_12 && is_halt)
			halted <= 1'b1;
	end

	// normal flow rotates the hot bit one place, step 24 wraps to step 1 by itself
	always_comb
	begin
		next_state = seq_state_t'({state[22:0], state[23]});
		case (state)
			state_8:
				if (class_code inside {mov_8, alu, setab})
					next_state = state_1;
			state_12:
				if (is_halt)
					next_state = state_12;
				else if (class_code inside {load_store, mov16_halt})
					next_state = state_1;
			state_14:
				// goto is the only class still running past here
				if (class_code == inc_xy)
					next_state = state_1;
			default:
				next_state = seq_state_t'({state[22:0], state[23]});
		endcase
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the relay core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module relay_cpu_tb \
	-f flist.f \
	-o relay_cpu_sim
./obj_dir/relay_cpu_sim

// ==== tests/relay_cpu_chk.sv ====
// relay core checker for one-hot sequencing, step counts, Wishbone request stability and halt
`timescale 1ns/1ns
`default_nettype none

module relay_cpu_chk (
	input logic                    clock,
	input logic                    rst,
	input relay_pkg::seq_state_t   state,
	input relay_pkg::instr_class_t class_code,
	input logic                    is_halt,
	input logic                    halted,
	input logic                    cyc,
	input logic                    stb,
	input logic                    we,
	input logic                    ack,
	input relay_pkg::addr_t        adr
);
	import relay_pkg::*;

	// final step of the running instruction as given by its class step count
	seq_state_t last_step;

	assign last_step = seq_state_t'(24'd1 << (step_count(class_code) - 1));

	// exactly one sequencer step is active in every cycle
	state_onehot: assert property (@(posedge clock) disable iff (rst) $onehot(state))
		else $error("sequencer state is not one-hot");

	// away from step 1 the sequencer goes back there right after the last step of the class
	step_return: assert property (@(posedge clock) disable iff (rst)
		(state != state_1 && !(is_halt && state == state_12)) |=>
		((state == state_1) == $past(state == last_step)))
		else $error("sequencer did not follow the step count of the instruction class");

	// a waiting request keeps its cycle, address and direction until the slave acknowledges
	request_stable: assert property (@(posedge clock) disable iff (rst)
		(cyc && stb && !ack) |=> (cyc && stb && $stable(adr) && $stable(we)))
		else $error("wishbone request changed while waiting for ack");

	// only reset can clear the halted flag
	halt_sticky: assert property (@(posedge clock) disable iff (rst) halted |=> halted)
		else $error("halted fell without reset");

endmodule

// the sequencer state, class and halt signals are picked up at the top level next to the bus
bind relay_cpu_top relay_cpu_chk u_chk (
	.clock      (clock),
	.rst        (rst),
	.state      (state),
	.class_code (class_code),
	.is_halt    (is_halt),
	.halted     (halted),
	.cyc        (wb_cyc),
	.stb        (wb_stb),
	.we         (wb_we),
	.ack        (wb_ack),
	.adr        (wb_adr)
);

`default_nettype wire

// ==== tests/relay_cpu_tb.sv ====
// relay core testbench with a Wishbone memory model, directed programs and stored-result checks
`timescale 1ns/1ns
`default_nettype none

module relay_cpu_tb;
	import relay_pkg::*;

	localparam data_t op_inc_xy = 8'hb0;
	localparam data_t op_mov16  = 8'ha0;
	localparam data_t op_halt   = 8'hae;
	localparam data_t op_goto   = 8'hc0;

	localparam logic [2:0] idx_a  = 3'd0;
	localparam logic [2:0] idx_c  = 3'd2;
	localparam logic [2:0] idx_m1 = 3'd4;
	localparam logic [2:0] idx_m2 = 3'd5;
	localparam logic [2:0] idx_x  = 3'd6;
	localparam logic [2:0] idx_y  = 3'd7;

	// upper bound on executed instructions over move pairs, both ALU runs, loads, X:Y and halt
	localparam int unsigned instr_total = 56 * 9 + 1 + 2 * 52 + 41 + 44 + 13;
	// each of the 24 steps of every instruction may wait up to three cycles for ack
	// the added margin covers the reset and idle cycles of each run
	localparam int unsigned watchdog_ns = instr_total * 24 * 4 * 8 + 20000;

	logic  clock;
	logic  rst;
	addr_t wb_adr;
	data_t wb_dat_o;
	data_t wb_dat_i;
	logic  wb_we;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_ack;
	logic  halted;

	data_t       mem [0:65535];
	data_t       prog [$];
	addr_t       exp_addr_q [$];
	data_t       exp_data_q [$];
	addr_t       wr_addr_q [$];
	data_t       wr_data_q [$];
	addr_t       read_addr_q [$];
	int unsigned access_count;
	int          seed;
	int          rnd;
	logic        pending;
	logic [1:0]  wait_left;

	relay_cpu_top #(
		.reset_vector (16'h0000)
	) UUT (
		.clock    (clock),
		.rst      (rst),
		.wb_adr   (wb_adr),
		.wb_dat_o (wb_dat_o),
		.wb_dat_i (wb_dat_i),
		.wb_we    (wb_we),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_ack   (wb_ack),
		.halted   (halted)
	);

	always #4 clock = ~clock;

	// Wishbone slave that waits a random 0 to 3 cycles before each ack
	always
	begin
		@(posedge clock);
		#1;
		// the acknowledged transfer ended on this edge
		if (wb_ack)
			wb_ack = 1'b0;
		if (wb_cyc && wb_stb)
		begin
			if (!pending)
			begin
				pending = 1'b1;
				rnd = $random(seed);
				wait_left = rnd[1:0];
			end
			if (wait_left != 2'd0)
				wait_left = wait_left - 2'd1;
			else
			begin
				if (wb_we)
				begin
					mem[wb_adr] = wb_dat_o;
					wr_addr_q.push_back(wb_adr);
					wr_data_q.push_back(wb_dat_o);
				end
				else
				begin
					wb_dat_i = mem[wb_adr];
					read_addr_q.push_back(wb_adr);
				end
				access_count++;
				pending = 1'b0;
				wb_ack = 1'b1;
			end
		end
	end

	initial
	begin
		#(watchdog_ns);
		stop_run("simulation did not finish in time");
	end

	task automatic stop_run(input string text);
		$display("%s", text);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	// instruction encoders following the byte layouts of each class
	function automatic data_t mov_op(input logic [2:0] dst, input logic [2:0] src);
		return {2'b00, dst, src};
	endfunction

	function automatic data_t setab_op(input logic dest, input logic [4:0] value);
		return {2'b01, dest, value};
	endfunction

	function automatic data_t alu_op(input logic dest, input logic [2:0] func);
		return {4'b1000, dest, func};
	endfunction

	function automatic data_t ldst_op(input logic store, input logic [1:0] rsel);
		return {4'b1001, store, 1'b0, rsel};
	endfunction

	function automatic data_t sext5(input logic [4:0] v);
		return {{3{v[4]}}, v};
	endfunction

	// ALU results for B = F5 and C = 0C with eight-bit wrap
	function automatic data_t expected_alu(input int func);
		case (func)
			0: return 8'h01;
			1: return 8'hf6;
			2: return 8'h04;
			3: return 8'hfd;
			4: return 8'hf9;
			5: return 8'h0a;
			6: return 8'hea;
			default: return 8'h00;
		endcase
	endfunction

	task automatic put_byte(input data_t b);
		prog.push_back(b);
	endtask

	// sets M1:M2 to FF and the sign-extended low byte with A or B as scratch
	task automatic point_m_at(input logic tmp_b, input logic [4:0] low);
		put_byte(setab_op(tmp_b, 5'h1f));
		put_byte(mov_op(idx_m1, {2'b00, tmp_b}));
		put_byte(setab_op(tmp_b, low));
		put_byte(mov_op(idx_m2, {2'b00, tmp_b}));
	endtask

	task automatic store_expected(input logic [1:0] rsel, input logic [4:0] low, input data_t value);
		put_byte(ldst_op(1'b1, rsel));
		exp_addr_q.push_back({8'hff, sext5(low)});
		exp_data_q.push_back(value);
	endtask

	// puts the core in reset and refills memory with an address-derived pattern
	task automatic start_test();
		addr_t a;
		@(posedge clock);
		#1;
		rst = 1'b1;
		for (int i = 0; i < 65536; i++)
		begin
			a = addr_t'(i);
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h69;
		end
		prog.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		read_addr_q.delete();
	endtask

	// loads the program at address 0, runs it to halt and compares the bus writes
	task automatic run_program(input string name);
		int unsigned seen;
		for (int i = 0; i < prog.size(); i++)
			mem[addr_t'(i)] = prog[i];
		repeat (4) @(posedge clock);
		#1;
		rst = 1'b0;
		do
		begin
			@(posedge clock);
			#1;
		end
		while (!halted);
		// a halted core must leave the bus alone
		seen = access_count;
		repeat (40)
		begin
			@(posedge clock);
			#1;
			if (wb_cyc || wb_stb || access_count != seen)
				stop_run($sformatf("%s: a bus cycle started after halt", name));
		end
		if (wr_addr_q.size() != exp_addr_q.size())
			stop_run($sformatf("%s: %0d bus writes seen where %0d were expected",
				name, wr_addr_q.size(), exp_addr_q.size()));
		for (int i = 0; i < wr_addr_q.size(); i++)
		begin
			check_addr(name, exp_addr_q[i], wr_addr_q[i]);
			check_byte(name, exp_data_q[i], wr_data_q[i]);
		end
	endtask

	// for every ordered register pair the value goes from A to src to dst to C and out to memory
	task automatic moves_all_pairs();
		int unsigned k;
		logic [4:0]  imm;
		start_test();
		k = 0;
		for (int s = 0; s < 8; s++)
		begin
			for (int d = 0; d < 8; d++)
			begin
				if (s != d)
				begin
					imm = 5'(k * 7 + 3);
					put_byte(setab_op(1'b0, imm));
					if (s != 0)
						put_byte(mov_op(3'(s), idx_a));
					put_byte(mov_op(3'(d), 3'(s)));
					if (d != 2)
						put_byte(mov_op(idx_c, 3'(d)));
					point_m_at(1'b1, 5'(k));
					store_expected(2'd2, 5'(k), sext5(imm));
					k++;
				end
			end
		end
		put_byte(op_halt);
		run_program("setab and mov_8 pairs");
	endtask

	task automatic alu_all_functions(input string name);
		start_test();
		// B = F5 and C = 0C through sign-extended immediates
		put_byte(setab_op(1'b1, 5'h15));
		put_byte(setab_op(1'b0, 5'h0c));
		put_byte(mov_op(idx_c, idx_a));
		for (int f = 0; f < 8; f++)
		begin
			point_m_at(1'b0, 5'(f));
			put_byte(alu_op(f[0], 3'(f)));
			store_expected(f[0] ? 2'd3 : 2'd0, 5'(f), expected_alu(f));
		end
		put_byte(op_halt);
		run_program(name);
	endtask

	// each of A to D loads a preset byte and stores it somewhere else
	task automatic load_then_store();
		data_t preset;
		start_test();
		for (int r = 0; r < 4; r++)
		begin
			preset = 8'ha5 ^ 8'(r * 60);
			mem[{8'hff, 8'(r)}] = preset;
			point_m_at(1'b0, 5'(r));
			put_byte(ldst_op(1'b0, 2'(r)));
			point_m_at(r == 0, 5'(24 + r));
			store_expected(2'(r), 5'(24 + r), preset);
		end
		put_byte(op_halt);
		run_program("load then store");
	endtask

	task automatic xy_and_goto();
		addr_t goto_at;
		addr_t jump_target;
		logic  found;
		start_test();
		jump_target = 16'h0240;
		// M1:M2 = 0F:FF, so mov16 gives X:Y = 0FFF and inc_xy carries into X
		put_byte(setab_op(1'b0, 5'h0f));
		put_byte(mov_op(idx_m1, idx_a));
		put_byte(setab_op(1'b0, 5'h1f));
		put_byte(mov_op(idx_m2, idx_a));
		put_byte(op_mov16);
		point_m_at(1'b1, 5'h0e);
		put_byte(mov_op(idx_a, idx_y));
		store_expected(2'd0, 5'h0e, 8'hff);
		put_byte(op_inc_xy);
		point_m_at(1'b1, 5'h10);
		put_byte(mov_op(idx_a, idx_x));
		store_expected(2'd0, 5'h10, 8'h10);
		point_m_at(1'b1, 5'h11);
		put_byte(mov_op(idx_a, idx_y));
		store_expected(2'd0, 5'h11, 8'h00);
		// a second increment stays inside Y
		put_byte(op_inc_xy);
		point_m_at(1'b1, 5'h12);
		put_byte(mov_op(idx_a, idx_y));
		store_expected(2'd0, 5'h12, 8'h01);
		point_m_at(1'b1, 5'h13);
		put_byte(mov_op(idx_a, idx_x));
		store_expected(2'd0, 5'h13, 8'h10);
		goto_at = addr_t'(prog.size());
		put_byte(op_goto);
		put_byte(jump_target[15:8]);
		put_byte(jump_target[7:0]);
		// a goto that falls through halts here and fails the fetch address check
		put_byte(op_halt);
		mem[jump_target] = op_halt;
		run_program("mov16 and inc_xy");
		found = 1'b0;
		for (int i = 0; i + 1 < read_addr_q.size(); i++)
		begin
			if (!found && read_addr_q[i] == goto_at + 16'd2)
			begin
				found = 1'b1;
				check_addr("goto target fetch", jump_target, read_addr_q[i + 1]);
			end
		end
		if (!found)
			stop_run("the second goto byte was never read");
	endtask

	// code after the halt byte must never reach the bus
	task automatic halt_stops_bus();
		start_test();
		put_byte(setab_op(1'b0, 5'h05));
		point_m_at(1'b1, 5'h14);
		store_expected(2'd0, 5'h14, 8'h05);
		put_byte(op_halt);
		put_byte(setab_op(1'b0, 5'h09));
		point_m_at(1'b1, 5'h15);
		put_byte(ldst_op(1'b1, 2'd0));
		run_program("halt");
	endtask

	initial
	begin
		clock = 1'b0;
		rst = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = 8'h00;
		seed = 32'hf6e27466;
		pending = 1'b0;
		wait_left = 2'd0;
		access_count = 0;
		moves_all_pairs();
		alu_all_functions("alu functions");
		load_then_store();
		xy_and_goto();
		halt_stops_bus();
		// same program again under a different run of ack delays
		alu_all_functions("alu with other ack delays");
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
